// ==== include/mesh_params.svh ====
////////////////////////////////////////////////////////////
// Mesh size, scratchpad depth and Wishbone address fields
// for the 2x2 tiled mesh
////////////////////////////////////////////////////////////

`ifndef MESH_PARAMS_SVH
`define MESH_PARAMS_SVH

// Mesh dimensions in routers
`define MESH_X 2
`define MESH_Y 2

// Scratchpad geometry, 32-bit words
`define SPM_WORDS 64
`define SPM_AW 6

// Wishbone address width
`define WB_AW 32

// Tile select bits, x at this bit and y just above it
`define TILE_SEL_LSB 8

`endif

// ==== hw/mesh_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the mesh: coordinates, port directions,
// flit kinds, request/response payloads, flit and link
////////////////////////////////////////////////////////////

`include "mesh_params.svh"

package mesh_pkg;

  // Router port count, four neighbours plus the local tile
  localparam int unsigned num_ports = 5;

  typedef struct packed {
    logic x;
    logic y;
  } coord_t;

  // Port order also indexes the router link arrays
  typedef enum logic [2:0] {
    dir_north,
    dir_east,
    dir_south,
    dir_west,
    dir_local
  } port_e;

  typedef enum logic [1:0] {
    kind_rd_req,
    kind_wr_req,
    kind_rsp
  } flit_kind_e;

  ////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////

  // Word index padded out to 16 bits
  typedef struct packed {
    logic [15-`SPM_AW:0] pad;
    logic [`SPM_AW-1:0]  idx;
    logic [3:0]          sel;
    logic [31:0]         wdata;
  } req_payload_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic [19:0] pad;
  } rsp_payload_t;

  // Same 52 bits, read as request or response by flit kind
  typedef union packed {
    req_payload_t req;
    rsp_payload_t rsp;
  } payload_u;

  typedef struct packed {
    flit_kind_e kind;
    coord_t     src;
    coord_t     dst;
    payload_u   payload;
  } flit_t;

  // Ready runs the other way as its own bit
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

endpackage

// ==== hw/mesh_router.sv ====
////////////////////////////////////////////////////////////
// Five-port mesh router
// Two-entry input buffers, XY routing, round-robin output
// arbiters with grant hold under back-pressure
////////////////////////////////////////////////////////////

module mesh_router (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  mesh_pkg::coord_t                          coord_i,
  input  mesh_pkg::link_t [mesh_pkg::num_ports-1:0] in_link_i,
  output logic [mesh_pkg::num_ports-1:0]            in_ready_o,
  output mesh_pkg::link_t [mesh_pkg::num_ports-1:0] out_link_o,
  input  logic [mesh_pkg::num_ports-1:0]            out_ready_i
);

  localparam int unsigned np = mesh_pkg::num_ports;

  logic [np-1:0]                   head_valid;
  mesh_pkg::flit_t [np-1:0]        head_flit;
  logic [np-1:0]                   pop;
  mesh_pkg::port_e                 route [np];
  logic [np-1:0]                   req [np];
  logic [2:0]                      out_grant [np];
  logic [np-1:0]                   out_fire;

  ////////////////////////////////////////////////////////////
  // Input buffers
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < np; i++) begin : gen_in
    mesh_pkg::flit_t [1:0] mem_q;
    logic                  wr_ptr_q;
    logic                  rd_ptr_q;
    logic [1:0]            cnt_q;
    logic                  push;

    // Ready follows occupancy alone
    assign in_ready_o[i] = (cnt_q != 2'd2);
    assign push          = in_link_i[i].valid && in_ready_o[i];
    assign head_valid[i] = (cnt_q != 2'd0);
    assign head_flit[i]  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        cnt_q    <= 2'd0;
      end else begin
        if (push) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (pop[i]) begin
          rd_ptr_q <= ~rd_ptr_q;
        end
        case ({push, pop[i]})
          2'b10:   cnt_q <= cnt_q + 2'd1;
          2'b01:   cnt_q <= cnt_q - 2'd1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= in_link_i[i].flit;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // XY routing of each head flit
  ////////////////////////////////////////////////////////////

  always_comb begin
    mesh_pkg::coord_t dst;
    dst = '0;
    for (int i = 0; i < np; i++) begin
      dst = head_flit[i].dst;
      // X first, north is y + 1
      if (dst.x > coord_i.x) begin
        route[i] = mesh_pkg::dir_east;
      end else if (dst.x < coord_i.x) begin
        route[i] = mesh_pkg::dir_west;
      end else if (dst.y > coord_i.y) begin
        route[i] = mesh_pkg::dir_north;
      end else if (dst.y < coord_i.y) begin
        route[i] = mesh_pkg::dir_south;
      end else begin
        route[i] = mesh_pkg::dir_local;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < np; o++) begin
      for (int i = 0; i < np; i++) begin
        req[o][i] = head_valid[i] && (route[i] == mesh_pkg::port_e'(o));
      end
    end
  end

  // Each head wants one output, so at most one grant pops it
  always_comb begin
    pop = '0;
    for (int o = 0; o < np; o++) begin
      if (out_fire[o]) begin
        pop[out_grant[o]] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output arbiters
  ////////////////////////////////////////////////////////////

  for (genvar o = 0; o < np; o++) begin : gen_out
    logic [2:0] rr_q;
    logic [2:0] grant_q;
    logic [2:0] grant;
    logic       lock_q;
    logic       found;

    // Search from the pointer unless a stalled grant is held
    always_comb begin
      int unsigned cand;
      cand  = 0;
      grant = grant_q;
      found = lock_q;
      for (int k = 0; k < np; k++) begin
        cand = int'(rr_q) + k;
        if (cand >= np) begin
          cand = cand - np;
        end
        if (!found && req[o][cand]) begin
          found = 1'b1;
          grant = 3'(cand);
        end
      end
    end

    assign out_grant[o]        = grant;
    assign out_fire[o]         = found && out_ready_i[o];
    assign out_link_o[o].valid = found;
    assign out_link_o[o].flit  = head_flit[grant];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rr_q    <= 3'd0;
        grant_q <= 3'd0;
        lock_q  <= 1'b0;
      end else begin
        lock_q  <= found && !out_ready_i[o];
        grant_q <= grant;
        if (out_fire[o]) begin
          rr_q <= (grant == 3'(np - 1)) ? 3'd0 : grant + 3'd1;
        end
      end
    end

    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_link_o[o].valid && !out_ready_i[o]
      |=> out_link_o[o].valid && $stable(out_link_o[o].flit));
  end

endmodule

// ==== hw/wb_noc_bridge.sv ====
////////////////////////////////////////////////////////////
// Host bridge from Wishbone classic to mesh flits
// One transfer outstanding, local err for unmapped targets
////////////////////////////////////////////////////////////

`include "mesh_params.svh"

module wb_noc_bridge (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  logic [`WB_AW-1:0]  wb_adr_i,
  input  logic [31:0]        wb_dat_i,
  input  logic [3:0]         wb_sel_i,
  output logic [31:0]        wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  output mesh_pkg::link_t    link_o,
  input  logic               link_ready_i,
  input  mesh_pkg::link_t    link_i,
  output logic               link_ready_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_wait,
    st_done
  } state_e;

  // The bridge sits on tile (0,0)
  localparam mesh_pkg::coord_t host = '{x: 1'b0, y: 1'b0};

  state_e           state_q;
  logic             err_q;
  logic             start;
  logic             bad;
  logic             rsp_hit;
  mesh_pkg::coord_t tile;
  mesh_pkg::flit_t  req_d;
  mesh_pkg::flit_t  req_q;
  logic [31:0]      rdata_q;

  ////////////////////////////////////////////////////////////
  // Address decode and request build
  ////////////////////////////////////////////////////////////

  assign start  = wb_cyc_i && wb_stb_i && (state_q == st_idle);
  assign tile.x = wb_adr_i[`TILE_SEL_LSB];
  assign tile.y = wb_adr_i[`TILE_SEL_LSB+1];
  assign bad    = (|wb_adr_i[`WB_AW-1:`TILE_SEL_LSB+2]) || (tile == host);

  always_comb begin
    req_d                     = '0;
    req_d.kind                = wb_we_i ? mesh_pkg::kind_wr_req : mesh_pkg::kind_rd_req;
    req_d.src                 = host;
    req_d.dst                 = tile;
    // Byte address, so the word index starts at bit 2
    req_d.payload.req.idx     = wb_adr_i[`TILE_SEL_LSB-1 -: `SPM_AW];
    req_d.payload.req.sel     = wb_sel_i;
    req_d.payload.req.wdata   = wb_dat_i;
  end

  assign rsp_hit = (state_q == st_wait) && link_i.valid &&
                   (link_i.flit.kind == mesh_pkg::kind_rsp);

  ////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            err_q   <= bad;
            state_q <= bad ? st_done : st_send;
          end
        end
        st_send: begin
          if (link_ready_i) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (rsp_hit) begin
            state_q <= st_done;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_q <= req_d;
    end
    if (rsp_hit) begin
      rdata_q <= link_i.flit.payload.rsp.rdata;
    end
  end

  assign link_o.valid = (state_q == st_send);
  assign link_o.flit  = req_q;
  assign link_ready_o = (state_q == st_wait);
  assign wb_dat_o     = rdata_q;
  assign wb_ack_o     = (state_q == st_done) && !err_q;
  assign wb_err_o     = (state_q == st_done) && err_q;

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_i |-> wb_cyc_i);

endmodule

// ==== hw/spm_endpoint.sv ====
////////////////////////////////////////////////////////////
// Scratchpad memory endpoint
// Serves read/write request flits, returns response flits
////////////////////////////////////////////////////////////

`include "mesh_params.svh"

module spm_endpoint (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  mesh_pkg::coord_t coord_i,
  input  mesh_pkg::link_t  link_i,
  output logic             link_ready_o,
  output mesh_pkg::link_t  link_o,
  input  logic             link_ready_i
);

  logic [31:0]             mem_q [`SPM_WORDS];
  mesh_pkg::req_payload_t  req;
  logic                    is_wr;
  logic                    accept;
  logic [31:0]             word;
  logic                    rsp_valid_q;
  mesh_pkg::flit_t         rsp_q;

  assign req          = link_i.flit.payload.req;
  assign is_wr        = (link_i.flit.kind == mesh_pkg::kind_wr_req);
  // No new request while a response waits
  assign link_ready_o = !rsp_valid_q;
  assign accept       = link_i.valid && link_ready_o;

  // Stored word, merged with the selected write bytes
  always_comb begin
    word = mem_q[req.idx];
    if (is_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (req.sel[b]) begin
          word[8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (link_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (is_wr) begin
        mem_q[req.idx] <= word;
      end
      rsp_q.kind              <= mesh_pkg::kind_rsp;
      rsp_q.src               <= coord_i;
      rsp_q.dst               <= link_i.flit.src;
      rsp_q.payload.rsp.rdata <= word;
      rsp_q.payload.rsp.pad   <= '0;
    end
  end

  assign link_o.valid = rsp_valid_q;
  assign link_o.flit  = rsp_q;

  // Responses only ever route to the host
  a_no_rsp_in: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> link_i.flit.kind != mesh_pkg::kind_rsp);

endmodule

// ==== hw/mesh_top.sv ====
////////////////////////////////////////////////////////////
// 2x2 mesh top level
// Routers, host bridge on (0,0), scratchpads elsewhere,
// neighbour links and edge tie-offs
////////////////////////////////////////////////////////////

`include "mesh_params.svh"

module mesh_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [`WB_AW-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o
);

  localparam int unsigned np = mesh_pkg::num_ports;

  mesh_pkg::link_t [`MESH_X-1:0][`MESH_Y-1:0][np-1:0] link_in, link_out;
  logic [`MESH_X-1:0][`MESH_Y-1:0][np-1:0]            ready_in, ready_out;

  for (genvar x = 0; x < `MESH_X; x++) begin : gen_x
    for (genvar y = 0; y < `MESH_Y; y++) begin : gen_y
      localparam mesh_pkg::coord_t here = '{x: 1'(x), y: 1'(y)};

      mesh_router i_router (
        .clk_i,
        .arst_n_i,
        .coord_i     (here),
        .in_link_i   (link_in[x][y]),
        .in_ready_o  (ready_in[x][y]),
        .out_link_o  (link_out[x][y]),
        .out_ready_i (ready_out[x][y])
      );

      ////////////////////////////////////////////////////////////
      // Local endpoint
      ////////////////////////////////////////////////////////////

      if (x == 0 && y == 0) begin : gen_host
        wb_noc_bridge i_bridge (
          .clk_i,
          .arst_n_i,
          .wb_cyc_i,
          .wb_stb_i,
          .wb_we_i,
          .wb_adr_i,
          .wb_dat_i,
          .wb_sel_i,
          .wb_dat_o,
          .wb_ack_o,
          .wb_err_o,
          .link_o       (link_in[x][y][mesh_pkg::dir_local]),
          .link_ready_i (ready_in[x][y][mesh_pkg::dir_local]),
          .link_i       (link_out[x][y][mesh_pkg::dir_local]),
          .link_ready_o (ready_out[x][y][mesh_pkg::dir_local])
        );
      end else begin : gen_spm
        spm_endpoint i_spm (
          .clk_i,
          .arst_n_i,
          .coord_i      (here),
          .link_i       (link_out[x][y][mesh_pkg::dir_local]),
          .link_ready_o (ready_out[x][y][mesh_pkg::dir_local]),
          .link_o       (link_in[x][y][mesh_pkg::dir_local]),
          .link_ready_i (ready_in[x][y][mesh_pkg::dir_local])
        );
      end

      // Neighbour in direction d, north is y + 1
      for (genvar d = 0; d < 4; d++) begin : gen_dir
        localparam int nx = (d == int'(mesh_pkg::dir_east)) ? x + 1 :
                            (d == int'(mesh_pkg::dir_west)) ? x - 1 : x;
        localparam int ny = (d == int'(mesh_pkg::dir_north)) ? y + 1 :
                            (d == int'(mesh_pkg::dir_south)) ? y - 1 : y;
        localparam int od = (d + 2) % 4;

        if (nx < 0 || nx >= `MESH_X || ny < 0 || ny >= `MESH_Y) begin : gen_tie_off
          assign link_in[x][y][d]   = '0;
          // Stray flits at the edge just drain
          assign ready_out[x][y][d] = 1'b1;
        end else begin : gen_con
          assign link_in[x][y][d]   = link_out[nx][ny][od];
          assign ready_out[x][y][d] = ready_in[nx][ny][od];
        end
      end
    end
  end

endmodule

// ==== verification/mesh_top_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the 2x2 mesh top level
// Clock, reset, Wishbone driver, stimulus table,
// reference memory model and checks
////////////////////////////////////////////////////////////

`include "mesh_params.svh"

module mesh_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned max_wait = 200;

  // One Wishbone transfer with its expected outcome
  typedef struct packed {
    logic [2:0]        group;
    logic              we;
    logic [`WB_AW-1:0] adr;
    logic [3:0]        sel;
    logic [31:0]       data;
    logic              exp_err;
  } entry_t;

  logic              clk_i;
  logic              arst_n_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [`WB_AW-1:0] wb_adr_i;
  logic [31:0]       wb_dat_i;
  logic [3:0]        wb_sel_i;
  logic [31:0]       wb_dat_o;
  logic              wb_ack_o;
  logic              wb_err_o;

  entry_t      stim_q [$];
  logic [31:0] ref_mem [4][`SPM_WORDS];
  int unsigned pass_count;
  int unsigned err_count;
  bit          timed_out;

  mesh_top mesh_top_i (
    .clk_i,
    .arst_n_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_sel_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  ////////////////////////////////////////////////////////////

  // Byte address: word index at 7:2, x at bit 8, y at bit 9
  function automatic logic [`WB_AW-1:0] tile_addr(input int x, input int y, input int idx);
    logic [`WB_AW-1:0] a;
    a = '0;
    a[`TILE_SEL_LSB]                = x[0];
    a[`TILE_SEL_LSB+1]              = y[0];
    a[`TILE_SEL_LSB-1 -: `SPM_AW]   = idx[`SPM_AW-1:0];
    return a;
  endfunction

  function automatic void add_entry(input int group, input bit we,
                                    input logic [`WB_AW-1:0] adr,
                                    input logic [3:0] sel, input bit exp_err);
    entry_t e;
    e.group   = group[2:0];
    e.we      = we;
    e.adr     = adr;
    e.sel     = sel;
    e.data    = $urandom();
    e.exp_err = exp_err;
    stim_q.push_back(e);
  endfunction

  function automatic void build_table();
    // Write then read back, each memory tile
    for (int t = 1; t < 4; t++) begin
      add_entry(2, 1'b1, tile_addr(t % 2, t / 2, 5), 4'hf, 1'b0);
      add_entry(2, 1'b0, tile_addr(t % 2, t / 2, 5), 4'hf, 1'b0);
    end
    // Same index in all tiles, different data
    for (int t = 1; t < 4; t++) begin
      add_entry(3, 1'b1, tile_addr(t % 2, t / 2, 9), 4'hf, 1'b0);
    end
    for (int t = 1; t < 4; t++) begin
      add_entry(3, 1'b0, tile_addr(t % 2, t / 2, 9), 4'hf, 1'b0);
    end
    // Partial byte selects over a full word
    add_entry(4, 1'b1, tile_addr(0, 1, 12), 4'hf, 1'b0);
    add_entry(4, 1'b1, tile_addr(0, 1, 12), 4'b0101, 1'b0);
    add_entry(4, 1'b0, tile_addr(0, 1, 12), 4'hf, 1'b0);
    add_entry(4, 1'b1, tile_addr(1, 1, 20), 4'hf, 1'b0);
    add_entry(4, 1'b1, tile_addr(1, 1, 20), 4'b1000, 1'b0);
    add_entry(4, 1'b0, tile_addr(1, 1, 20), 4'hf, 1'b0);
    // Host tile and out-of-map addresses, then a good read
    add_entry(5, 1'b0, tile_addr(0, 0, 3), 4'hf, 1'b1);
    add_entry(5, 1'b1, tile_addr(0, 0, 7), 4'hf, 1'b1);
    add_entry(5, 1'b0, tile_addr(1, 0, 5) | 32'h0000_0400, 4'hf, 1'b1);
    add_entry(5, 1'b1, tile_addr(1, 1, 9) | 32'h8000_0000, 4'hf, 1'b1);
    add_entry(5, 1'b0, tile_addr(1, 0, 5), 4'hf, 1'b0);
    // Far tile alternating with the two near tiles
    for (int i = 0; i < 6; i++) begin
      add_entry(6, 1'b1, tile_addr(1, 1, 32 + i), 4'hf, 1'b0);
      add_entry(6, 1'b1, tile_addr(1 - i % 2, i % 2, 32 + i), 4'hf, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      add_entry(6, 1'b0, tile_addr(1, 1, 32 + i), 4'hf, 1'b0);
      add_entry(6, 1'b0, tile_addr(1 - i % 2, i % 2, 32 + i), 4'hf, 1'b0);
    end
  endfunction

  // Word the DUT should return, write bytes merged by select
  function automatic logic [31:0] predict_word(input entry_t e);
    logic [1:0]         t;
    logic [`SPM_AW-1:0] idx;
    logic [31:0]        w;
    t   = e.adr[`TILE_SEL_LSB+1 -: 2];
    idx = e.adr[`TILE_SEL_LSB-1 -: `SPM_AW];
    w   = ref_mem[t][idx];
    if (e.we) begin
      for (int b = 0; b < 4; b++) begin
        if (e.sel[b]) begin
          w[8*b +: 8] = e.data[8*b +: 8];
        end
      end
      ref_mem[t][idx] = w;
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Wishbone driver and checks
  ////////////////////////////////////////////////////////////

  task automatic run_transfer(input entry_t e, input int n);
    int unsigned cycles;
    bit          done;
    bit          ok;
    logic        ack;
    logic        err;
    logic [31:0] dat;
    logic [31:0] exp_word;
    @(posedge clk_i);
    #2;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = e.we;
    wb_adr_i = e.adr;
    wb_dat_i = e.data;
    wb_sel_i = e.sel;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < max_wait) begin
      @(negedge clk_i);
      cycles++;
      done = wb_ack_o || wb_err_o;
    end
    ack = wb_ack_o;
    err = wb_err_o;
    dat = wb_dat_o;
    @(posedge clk_i);
    #2;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!done) begin
      $display("Entry %0d: no ack or err within %0d cycles, transfer timed out", n, max_wait);
      timed_out = 1'b1;
      err_count++;
      return;
    end
    ok = 1'b1;
    if (e.exp_err) begin
      assert (err && !ack) else begin
        $display("** Error at %0t: entry %0d expected err only, got ack=%0b err=%0b",
                 $time, n, ack, err);
        ok = 1'b0;
      end
    end else begin
      exp_word = predict_word(e);
      assert (ack && !err) else begin
        $display("** Error at %0t: entry %0d expected ack only, got ack=%0b err=%0b",
                 $time, n, ack, err);
        ok = 1'b0;
      end
      assert (dat == exp_word) else begin
        $display("** Error at %0t: entry %0d data %h, expected %h", $time, n, dat, exp_word);
        ok = 1'b0;
      end
    end
    // Ack and err last one cycle
    @(negedge clk_i);
    assert (!wb_ack_o && !wb_err_o) else begin
      $display("** Error at %0t: entry %0d ack or err held past one cycle", $time, n);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
    end else begin
      err_count++;
    end
    $display("Entry %0d group %0d %s adr=%h sel=%h: %s", n, e.group,
             e.we ? "write" : "read ", e.adr, e.sel, ok ? "ok" : "MISMATCH");
  endtask

  initial begin
    bit idle_ok;
    arst_n_i   = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    wb_sel_i   = '0;
    pass_count = 0;
    err_count  = 0;
    timed_out  = 1'b0;
    idle_ok    = 1'b1;
    void'($urandom(32'h519db733));
    build_table();

    // Quiet bus during and just after reset
    repeat (16) begin
      @(negedge clk_i);
      assert (!wb_ack_o && !wb_err_o) else begin
        $display("** Error at %0t: ack or err high during reset", $time);
        idle_ok = 1'b0;
      end
    end
    @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      assert (!wb_ack_o && !wb_err_o) else begin
        $display("** Error at %0t: ack or err high with an idle bus", $time);
        idle_ok = 1'b0;
      end
    end
    if (idle_ok) begin
      pass_count++;
    end else begin
      err_count++;
    end
    $display("Entry 0 group 1 reset and idle bus: %s", idle_ok ? "ok" : "MISMATCH");

    for (int n = 0; n < int'(stim_q.size()) && !timed_out; n++) begin
      run_transfer(stim_q[n], n + 1);
    end

    $display("Summary: %0d of %0d entries ok, %0d failed", pass_count,
             stim_q.size() + 1, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
hw/mesh_pkg.sv
hw/mesh_router.sv
hw/wb_noc_bridge.sv
hw/spm_endpoint.sv
hw/mesh_top.sv
verification/mesh_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the 2x2 mesh testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      := mesh_top_tb
FILELIST := src.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run $(TOP), pass or fail from $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
